//--- hdl/walkerPkg.sv
/*
  Sv32 page table walker definitions.
  Holds the address and page number widths and the PTE, satp and TLB fill
  layouts. Also holds the page type encoding, the fault bundle, the walker
  state encoding and the decoded PTE conditions shared by the walker blocks.
*/

package walkerPkg;

  ////////////////////
  // Sv32 geometry
  ////////////////////

  // Data and virtual address width of the core
  localparam int xlen = 32;
  // A physical page number is 22 bits, so physical addresses reach 34 bits
  localparam int ppnBits = 22;
  // Each of the two virtual page number segments is 10 bits
  localparam int vpnBits = 10;
  localparam int pageOffsetBits = 12;
  // A PTE is 4 bytes, so table indices are shifted left by two
  localparam int pteBytesLog2 = 2;

  ////////////////////
  // Page table entry
  ////////////////////

  // Flag byte in the low bits of every PTE, listed from bit 7 down to bit 0
  typedef struct packed {
    logic dirty;
    logic accessed;
    logic global;
    logic user;
    logic executable;
    logic writable;
    logic readable;
    logic valid;
  } pteFlags_t;

  // Full Sv32 PTE, where rsw is left for supervisor software
  typedef struct packed {
    logic [ppnBits-1:0] ppn;
    logic [1:0]         rsw;
    pteFlags_t          flags;
  } pte_t;

  // Only the root page number is used by the walker
  typedef struct packed {
    logic               mode;
    logic [8:0]         asid;
    logic [ppnBits-1:0] rootPpn;
  } satp_t;

  ////////////////////
  // TLB fill and faults
  ////////////////////

  // A leaf found at level 1 maps a 4 MiB megapage
  typedef enum logic [1:0] {
    pageKilo = 2'd0,
    pageMega = 2'd1
  } pageType_t;

  // What the walker hands to the TLB that missed
  typedef struct packed {
    pte_t      pte;
    pageType_t pageType;
  } tlbFill_t;

  // One bit per page fault kind, each a single-cycle pulse
  typedef struct packed {
    logic instr;
    logic load;
    logic store;
  } walkFaults_t;

  ////////////////////
  // Walker FSM
  ////////////////////

  // Gaps in the encoding leave room for deeper table levels
  typedef enum logic [2:0] {
    level0 = 3'd0,
    level1 = 3'd1,
    leaf   = 3'd5,
    idle   = 3'd6,
    fault  = 3'd7
  } walkState_t;

  // Conditions decoded from the PTE under inspection
  typedef struct packed {
    logic validPte;
    logic leafPte;
    logic accessAlert;
    logic megaMisaligned;
  } pteCond_t;

endpackage

//--- hdl/pteCapture.sv
/*
  PTE capture and decode.
  Saves each PTE returned by memory and passes a newly arriving one straight
  through, so the walker can act in the same cycle as the ready pulse.
  Decodes the flag byte into the conditions that steer the walk.
*/

`timescale 1ns/1ps

module pteCapture (
  input  logic               HCLK,
  input  logic               rst,
  input  walkerPkg::pte_t    readPte,
  input  logic               mmuReady,
  input  logic               memStore,
  output walkerPkg::pte_t    currentPte,
  output walkerPkg::pteCond_t cond
);

  import walkerPkg::*;

  // Last PTE that memory returned
  pte_t savedPte;

  // Flags of the PTE under inspection
  pteFlags_t flags;

  ////////////////////
  // Capture
  ////////////////////

  // Memory only holds readPte valid during the ready pulse
  always_ff @(posedge HCLK) begin
    if (rst) begin
      savedPte <= '0;
    end else if (mmuReady) begin
      savedPte <= readPte;
    end
  end

  // The arriving PTE wins over the saved one in its ready cycle
  always_comb begin
    if (mmuReady) begin
      currentPte = readPte;
    end else begin
      currentPte = savedPte;
    end
  end

  assign flags = currentPte.flags;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    // Any of R, W or X set marks a leaf, otherwise the PTE points one level down
    cond.leafPte = flags.readable | flags.writable | flags.executable;

    // Writable without readable is a reserved encoding and counts as invalid
    cond.validPte = flags.valid & ~(flags.writable & ~flags.readable);

    // Hardware does not set A or D bits here, software must have done it
    // A store also needs the page to be marked dirty already
    cond.accessAlert = ~flags.accessed | (memStore & ~flags.dirty);

    // A megapage leaf must have a zero low page number segment
    cond.megaMisaligned = |currentPte.ppn[vpnBits-1:0];
  end

endmodule

//--- hdl/walkControl.sv
/*
  Sv32 walk state machine.
  Steps through the two table levels on each memory ready pulse and decides
  between a TLB fill and a page fault. Drives the TLB write pulses, the fill
  data, the three fault pulses, the translate request and the core stall,
  all decoded from the next state.
*/

`timescale 1ns/1ps

module walkControl (
  input  logic                   HCLK,
  input  logic                   rst,
  input  logic                   itlbMiss,
  input  logic                   dtlbMiss,
  input  logic                   memStore,
  input  logic                   mmuReady,
  input  walkerPkg::pte_t        currentPte,
  input  walkerPkg::pteCond_t    cond,
  output walkerPkg::walkState_t  nextState,
  output logic                   mmuTranslate,
  output logic                   mmuStall,
  output walkerPkg::tlbFill_t    tlbFill,
  output logic                   itlbWrite,
  output logic                   dtlbWrite,
  output walkerPkg::walkFaults_t walkFaults
);

  import walkerPkg::*;

  walkState_t walkState;

  // Either TLB missing starts or continues a walk
  assign mmuTranslate = itlbMiss | dtlbMiss;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (rst) begin
      walkState <= idle;
    end else begin
      walkState <= nextState;
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    case (walkState)
      idle: begin
        // The first read goes out in the same cycle as the miss
        if (mmuTranslate) begin
          nextState = level1;
        end else begin
          nextState = idle;
        end
      end

      level1: begin
        // Hold until memory answers, the only back-pressure in the walk
        if (!mmuReady) begin
          nextState = level1;
        end else if (cond.validPte && cond.leafPte &&
                     !cond.megaMisaligned && !cond.accessAlert) begin
          nextState = leaf;
        end else if (cond.validPte && !cond.leafPte) begin
          nextState = level0;
        end else begin
          nextState = fault;
        end
      end

      level0: begin
        // Last level, so a pointer PTE here is also a fault
        if (!mmuReady) begin
          nextState = level0;
        end else if (cond.validPte && cond.leafPte && !cond.accessAlert) begin
          nextState = leaf;
        end else begin
          nextState = fault;
        end
      end

      leaf, fault: begin
        // A miss still high here is a new one, so walk again
        if (mmuTranslate) begin
          nextState = level1;
        end else begin
          nextState = idle;
        end
      end

      default: begin
        nextState = idle;
      end
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////

  always_comb begin
    tlbFill    = '0;
    itlbWrite  = 1'b0;
    dtlbWrite  = 1'b0;
    walkFaults = '0;
    // The core is held for the whole walk
    mmuStall   = 1'b1;

    case (nextState)
      idle: begin
        mmuStall = 1'b0;
      end

      leaf: begin
        tlbFill.pte = currentPte;
        // Leaving level 1 for a leaf means a megapage was found
        if (walkState == level1) begin
          tlbFill.pageType = pageMega;
        end else begin
          tlbFill.pageType = pageKilo;
        end
        // Data misses are served first, so the fill belongs to the data TLB
        dtlbWrite = dtlbMiss;
        itlbWrite = ~dtlbMiss;
      end

      fault: begin
        // Fault goes to whichever access caused the walk
        walkFaults.instr = ~dtlbMiss;
        walkFaults.load  = dtlbMiss & ~memStore;
        walkFaults.store = dtlbMiss & memStore;
        // Release the core early so it can take the trap
        mmuStall = 1'b0;
      end

      default: begin
        // Level states keep the defaults
        mmuStall = 1'b1;
      end
    endcase
  end

endmodule

//--- hdl/walkAddrGen.sv
/*
  PTE address generator.
  Picks the virtual address under translation and builds the physical
  address of the PTE for the state the walker is about to enter.
*/

`timescale 1ns/1ps

module walkAddrGen (
  input  walkerPkg::satp_t                 satp,
  input  logic [walkerPkg::xlen-1:0]       pc,
  input  logic [walkerPkg::xlen-1:0]       memAdr,
  input  logic                             dtlbMiss,
  input  logic [walkerPkg::ppnBits-1:0]    currentPpn,
  input  walkerPkg::walkState_t            nextState,
  output logic [walkerPkg::xlen-1:0]       mmuPAdr
);

  import walkerPkg::*;

  // Width of a full Sv32 physical address
  localparam int pAdrBits = ppnBits + vpnBits + pteBytesLog2;

  logic [xlen-1:0]     vAdr;
  logic [vpnBits-1:0]  vpn1;
  logic [vpnBits-1:0]  vpn0;
  logic [pAdrBits-1:0] pteAdr;

  ////////////////////
  // Virtual address
  ////////////////////

  // A data miss takes the walker first, matching the TLB write choice
  assign vAdr = dtlbMiss ? memAdr : pc;

  // The page offset is not needed to find the PTE
  assign vpn1 = vAdr[xlen-1 -: vpnBits];
  assign vpn0 = vAdr[pageOffsetBits +: vpnBits];

  ////////////////////
  // PTE address
  ////////////////////

  always_comb begin
    case (nextState)
      level1: begin
        // Root table comes from satp
        pteAdr = {satp.rootPpn, vpn1, {pteBytesLog2{1'b0}}};
      end

      level0, leaf, fault: begin
        // In leaf and fault the address is kept steady rather than dropped to zero
        pteAdr = {currentPpn, vpn0, {pteBytesLog2{1'b0}}};
      end

      default: begin
        pteAdr = '0;
      end
    endcase
  end

  // Physical memory here is 32 bits, the upper two address bits are dropped
  assign mmuPAdr = pteAdr[xlen-1:0];

endmodule

//--- hdl/pageTableWalker.sv
/*
  Sv32 page table walker top level.
  Serves instruction and data TLB misses by reading the two-level page
  table, then fills the TLB that missed or raises a page fault. Stalls the
  core while a walk is in progress.
*/

`timescale 1ns/1ps

module pageTableWalker (
  input  logic                          HCLK,
  input  logic                          rst,

  // Core side
  input  walkerPkg::satp_t              satp,
  input  logic [walkerPkg::xlen-1:0]    pc,
  input  logic [walkerPkg::xlen-1:0]    memAdr,
  input  logic                          itlbMiss,
  input  logic                          dtlbMiss,
  input  logic [1:0]                    memRw,
  output logic                          mmuStall,
  output walkerPkg::walkFaults_t        walkFaults,

  // TLB side, the fill goes to both TLBs
  output walkerPkg::tlbFill_t           tlbFill,
  output logic                          itlbWrite,
  output logic                          dtlbWrite,

  // Memory side
  input  walkerPkg::pte_t               readPte,
  input  logic                          mmuReady,
  output logic [walkerPkg::xlen-1:0]    mmuPAdr,
  output logic                          mmuTranslate
);

  import walkerPkg::*;

  // Bit 0 of the read/write pair flags a store
  logic       memStore;
  pte_t       currentPte;
  pteCond_t   cond;
  walkState_t nextState;

  assign memStore = memRw[0];

  ////////////////////
  // PTE capture
  ////////////////////

  pteCapture pteCapture_inst (
    .HCLK       (HCLK),
    .rst        (rst),
    .readPte    (readPte),
    .mmuReady   (mmuReady),
    .memStore   (memStore),
    .currentPte (currentPte),
    .cond       (cond)
  );

  ////////////////////
  // Walk FSM
  ////////////////////

  walkControl walkControl_inst (
    .HCLK         (HCLK),
    .rst          (rst),
    .itlbMiss     (itlbMiss),
    .dtlbMiss     (dtlbMiss),
    .memStore     (memStore),
    .mmuReady     (mmuReady),
    .currentPte   (currentPte),
    .cond         (cond),
    .nextState    (nextState),
    .mmuTranslate (mmuTranslate),
    .mmuStall     (mmuStall),
    .tlbFill      (tlbFill),
    .itlbWrite    (itlbWrite),
    .dtlbWrite    (dtlbWrite),
    .walkFaults   (walkFaults)
  );

  ////////////////////
  // Address generation
  ////////////////////

  // The next table is found through the page number of the current PTE
  walkAddrGen walkAddrGen_inst (
    .satp       (satp),
    .pc         (pc),
    .memAdr     (memAdr),
    .dtlbMiss   (dtlbMiss),
    .currentPpn (currentPte.ppn),
    .nextState  (nextState),
    .mmuPAdr    (mmuPAdr)
  );

endmodule

//--- bench/ptMemoryModel.sv
/*
  Page table memory for the walker testbench.
  Holds the two PTEs of one walk and answers each PTE read after a
  pseudo-random wait of 0 to 3 cycles with a one-cycle ready pulse.
  Keeps a log of the addresses it was asked to read.
*/

`timescale 1ns/1ps

module ptMemoryModel (
  input  logic            HCLK,
  input  logic            rst,
  input  logic [31:0]     mmuPAdr,
  input  logic            mmuStall,
  input  logic            itlbWrite,
  input  logic            dtlbWrite,
  output walkerPkg::pte_t readPte,
  output logic            mmuReady
);

  import walkerPkg::*;

  logic [31:0] slotAdr [0:1];
  pte_t        slotPte [0:1];
  logic [31:0] seenAdr [0:3];
  int          seenCount;
  logic [31:0] rng = 32'h8cfe;
  logic [31:0] reqAdr;
  logic [1:0]  waitLeft;
  logic        busy;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Addresses outside the two slots read back a pattern of the whole address
  function automatic pte_t lookup(input logic [31:0] adr);
    pte_t data;
    int   i;
    data = adr ^ 32'h5a5a_a5a5;
    for (i = 0; i < 2; i++) begin
      if (slotAdr[i] == adr) begin
        data = slotPte[i];
      end
    end
    return data;
  endfunction

  // Slot 0 holds the root table entry and slot 1 the level-0 entry
  task automatic loadWalk(input logic [31:0] adr1, input pte_t pte1,
                          input logic [31:0] adr0, input pte_t pte0);
    slotAdr[0] = adr1;
    slotPte[0] = pte1;
    slotAdr[1] = adr0;
    slotPte[1] = pte0;
    seenCount = 0;
  endtask

  // Memory outputs are quiet before the first clock edge
  initial begin
    mmuReady = 1'b0;
    readPte  = '0;
  end

  always @(posedge HCLK) begin
    if (rst) begin
      busy     <= 1'b0;
      mmuReady <= 1'b0;
      readPte  <= '0;
    end else begin
      mmuReady <= 1'b0;
      if (busy) begin
        if (waitLeft == 0) begin
          mmuReady <= 1'b1;
          readPte  <= lookup(reqAdr);
          busy     <= 1'b0;
        end else begin
          waitLeft <= waitLeft - 1;
        end
      end else if (mmuStall && !itlbWrite && !dtlbWrite) begin
        // A stalled cycle without a fill means the walker enters a level state
        busy     <= 1'b1;
        reqAdr   <= mmuPAdr;
        waitLeft <= rng[1:0];
        rng      <= xorshift(rng);
        if (seenCount < 4) begin
          seenAdr[seenCount] <= mmuPAdr;
        end
        seenCount <= seenCount + 1;
      end
    end
  end

endmodule

//--- bench/pageTableWalkerTb.sv
/*
  Testbench for the Sv32 page table walker.
  Runs a table of walks against a page table memory with random read
  latency and checks the end pulse, the fill, the stall and the PTE
  addresses of every walk.
*/

`timescale 1ns/1ps

module pageTableWalkerTb;

  import walkerPkg::*;

  localparam int numRows = 10;
  localparam int clkPeriod = 4;

  // End pulses are ordered itlbWrite, dtlbWrite, instr, load, store fault
  typedef struct packed {
    logic [1:0]  missKind;
    logic [31:0] vAdr;
    logic        store;
    pte_t        rootPte;
    pte_t        leafPte;
    logic [4:0]  expEnd;
    pageType_t   expType;
    logic [31:0] expAdr1;
    logic [31:0] expAdr0;
  } walkRow_t;

  logic        HCLK;
  logic        rst;
  satp_t       satp;
  logic [31:0] pc;
  logic [31:0] memAdr;
  logic        itlbMiss;
  logic        dtlbMiss;
  logic [1:0]  memRw;
  logic        mmuStall;
  walkFaults_t walkFaults;
  tlbFill_t    tlbFill;
  logic        itlbWrite;
  logic        dtlbWrite;
  pte_t        readPte;
  logic        mmuReady;
  logic [31:0] mmuPAdr;
  logic        mmuTranslate;

  walkRow_t rows [0:numRows-1];
  int       rowCount;
  int       rowIdx;
  int       checkCount;
  int       errorCount;

  pageTableWalker pageTableWalker_inst (.*);

  ptMemoryModel ptMemoryModel_inst (.*);

  always #(clkPeriod / 2) HCLK = ~HCLK;

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
               $time, name, expected, actual);
    end
  endtask

  // Miss kind bit 1 is a data miss and bit 0 an instruction miss
  // A level-0 address of zero marks a walk that ends after one read
  task automatic addRow(input logic [1:0] kind, input logic [31:0] vAdr, input logic store,
                        input pte_t rootPte, input pte_t leafPte, input logic [4:0] expEnd,
                        input pageType_t expType, input logic [31:0] expAdr1,
                        input logic [31:0] expAdr0);
    walkRow_t row;
    row.missKind = kind;
    row.vAdr     = vAdr;
    row.store    = store;
    row.rootPte  = rootPte;
    row.leafPte  = leafPte;
    row.expEnd   = expEnd;
    row.expType  = expType;
    row.expAdr1  = expAdr1;
    row.expAdr0  = expAdr0;
    rows[rowCount] = row;
    rowCount++;
  endtask

  ////////////////////
  // Walk table
  ////////////////////

  // The root table sits at 0x80000 and the level-0 table at 0x100000
  // The 4 KiB leaf maps page 0x12345
  task automatic fillTable();
    addRow(2'b01, 32'h0040_3000, 1'b0, 32'h0004_0001, 32'h048D_14CF,
           5'b10000, pageKilo, 32'h0008_0004, 32'h0010_000C);
    addRow(2'b10, 32'h8012_5000, 1'b0, 32'h0004_0001, 32'h048D_14CF,
           5'b01000, pageKilo, 32'h0008_0800, 32'h0010_0494);
    // Aligned megapage found at level 1
    addRow(2'b01, 32'h00C0_0010, 1'b0, 32'h0010_00CF, 32'h0,
           5'b10000, pageMega, 32'h0008_000C, 32'h0);
    // Megapage whose low page number segment is not zero
    addRow(2'b10, 32'h0100_0000, 1'b1, 32'h0010_04CF, 32'h0,
           5'b00001, pageKilo, 32'h0008_0010, 32'h0);
    // Leaf with valid clear
    addRow(2'b01, 32'h0000_5000, 1'b0, 32'h0004_0001, 32'h048D_14CE,
           5'b00100, pageKilo, 32'h0008_0000, 32'h0010_0014);
    // Writable but not readable at level 1
    addRow(2'b10, 32'h0080_0000, 1'b0, 32'h0010_00C5, 32'h0,
           5'b00010, pageKilo, 32'h0008_0008, 32'h0);
    // Accessed clear on a load
    addRow(2'b10, 32'h0040_7000, 1'b0, 32'h0004_0001, 32'h048D_148B,
           5'b00010, pageKilo, 32'h0008_0004, 32'h0010_001C);
    // Dirty clear on a store
    addRow(2'b10, 32'h0040_8000, 1'b1, 32'h0004_0001, 32'h048D_144F,
           5'b00001, pageKilo, 32'h0008_0004, 32'h0010_0020);
    // With both misses memAdr is walked and only the data TLB is written
    addRow(2'b11, 32'h8012_5000, 1'b1, 32'h0004_0001, 32'h048D_14CF,
           5'b01000, pageKilo, 32'h0008_0800, 32'h0010_0494);
    addRow(2'b11, 32'h0100_0000, 1'b0, 32'h0000_0000, 32'h0,
           5'b00010, pageKilo, 32'h0008_0010, 32'h0);
  endtask

  ////////////////////
  // One walk
  ////////////////////

  task automatic runWalk(input walkRow_t row);
    pte_t expPte;
    logic twoReads;
    logic done;
    twoReads = (row.expAdr0 != 0);
    expPte = twoReads ? row.leafPte : row.rootPte;
    ptMemoryModel_inst.loadWalk(row.expAdr1, row.rootPte, row.expAdr0, row.leafPte);
    memRw = {~row.store, row.store};
    // The address that should not be walked gets a different VPN1
    if (row.missKind[1]) begin
      memAdr = row.vAdr;
      pc = row.vAdr ^ 32'hFFC0_0000;
    end else begin
      pc = row.vAdr;
      memAdr = row.vAdr ^ 32'hFFC0_0000;
    end
    itlbMiss = row.missKind[0];
    dtlbMiss = row.missKind[1];
    done = 1'b0;
    while (!done) begin
      @(negedge HCLK);
      done = itlbWrite | dtlbWrite | (|walkFaults);
      if (!done) begin
        checkValue("mmuStall", mmuStall, 1'b1);
        checkValue("mmuTranslate", mmuTranslate, 1'b1);
      end
    end
    checkValue("end pulses", {itlbWrite, dtlbWrite, walkFaults}, row.expEnd);
    // A fill keeps the core stalled while a fault releases it
    checkValue("mmuStall", mmuStall, |row.expEnd[4:3]);
    if (|row.expEnd[4:3]) begin
      checkValue("tlbFill.pte", tlbFill.pte, expPte);
      checkValue("tlbFill.pageType", tlbFill.pageType, row.expType);
    end
    checkValue("read count", ptMemoryModel_inst.seenCount, twoReads ? 2 : 1);
    checkValue("level-1 PTE address", ptMemoryModel_inst.seenAdr[0], row.expAdr1);
    if (twoReads) begin
      checkValue("level-0 PTE address", ptMemoryModel_inst.seenAdr[1], row.expAdr0);
    end
    @(negedge HCLK);
    // The end pulse lasts a single cycle even with the miss still high
    checkValue("end pulses", {itlbWrite, dtlbWrite, walkFaults}, 5'b0);
    itlbMiss = 1'b0;
    dtlbMiss = 1'b0;
    @(negedge HCLK);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    HCLK = 1'b0;
    rst = 1'b1;
    satp = '0;
    satp.rootPpn = 22'h00080;
    pc = '0;
    memAdr = '0;
    itlbMiss = 1'b0;
    dtlbMiss = 1'b0;
    memRw = 2'b10;
    rowCount = 0;
    checkCount = 0;
    errorCount = 0;
    fillTable();
    repeat (3) @(posedge HCLK);
    @(negedge HCLK);
    rst = 1'b0;
    @(negedge HCLK);
    // Quiet walker after reset
    checkValue("mmuStall", mmuStall, 1'b0);
    checkValue("mmuTranslate", mmuTranslate, 1'b0);
    checkValue("end pulses", {itlbWrite, dtlbWrite, walkFaults}, 5'b0);
    for (rowIdx = 0; rowIdx < numRows; rowIdx++) begin
      runWalk(rows[rowIdx]);
    end
    $display("Walks: %0d, checks: %0d, errors: %0d", numRows, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // The budget is twice 16 cycles per walk
  initial begin
    #(numRows * 16 * 2 * clkPeriod);
    $display("Watchdog expired, a walk never reached its end pulse");
    $display("Walks: %0d, checks: %0d, errors: %0d", numRows, checkCount, errorCount);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- all.f
hdl/walkerPkg.sv
hdl/pteCapture.sv
hdl/walkControl.sv
hdl/walkAddrGen.sv
hdl/pageTableWalker.sv
bench/ptMemoryModel.sv
bench/pageTableWalkerTb.sv
